// ==== all.f ====
+incdir+include
src/npc_pkg.sv
src/npc_ifu.sv
src/npc_gpr.sv
src/npc_idu.sv
src/npc_exu.sv
src/npc_top.sv
tb/npc_tb.sv

// ==== Bender.yml ====
package:
  name: npc

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/npc_pkg.sv
      - src/npc_ifu.sv
      - src/npc_gpr.sv
      - src/npc_idu.sv
      - src/npc_exu.sv
      - src/npc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/npc_tb.sv

// ==== tb/npc_tb.sv ====
// testbench for npc_top: random program, AXI4-Lite memory model and reference model at the commit port
`timescale 1ns/1ps
`include "npc_params.svh"

module npc_tb import npc_pkg::*; ();

	localparam int n_commits   = 400;
	localparam int cycle_limit = n_commits * 16;
	// test slots
	localparam int t_reset  = 0;
	localparam int t_alu    = 1;
	localparam int t_hazard = 2;
	localparam int t_ctrl   = 3;
	localparam int t_fetch  = 4;
	localparam int t_zero   = 5;

	logic                   clk;
	logic                   rst;
	logic                   arvalid;
	logic [`NPC_ADDR_W-1:0] araddr;
	logic                   arready;
	logic                   rvalid;
	logic [31:0]            rdata;
	logic                   rready;
	logic                   commit_valid;
	npc_commit_t            commit;

	logic [31:0]            mem [0:63];
	string                  test_name [6] = '{"reset", "alu", "hazard", "control", "fetch", "x0"};
	int                     checks [6];
	int                     errors [6];

	// reference model state
	logic [31:0]            m_pc;
	logic [63:0]            m_regs [32];
	logic [4:0]             m_last_rd;
	// expected commit record of the current step
	logic [31:0]            e_pc;
	logic [4:0]             e_rd;
	logic                   e_wen;
	logic                   e_writes;
	logic [63:0]            e_val;
	logic                   e_dep;
	logic                   e_ctrl;

	// bus model state
	int                     ar_cnt;
	int                     r_cnt;
	logic                   ar_hs;
	logic                   r_hs;
	logic                   addr_open;
	logic [31:0]            r_addr;
	logic                   ar_wait_prev;
	logic [31:0]            ar_addr_prev;

	npc_top dut (
		.clk          (clk),
		.rst          (rst),
		.arvalid      (arvalid),
		.araddr       (araddr),
		.arready      (arready),
		.rvalid       (rvalid),
		.rdata        (rdata),
		.rready       (rready),
		.commit_valid (commit_valid),
		.commit       (commit)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// ****************************************
	// encoders and program
	// ****************************************

	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	// byte offset, bit 0 dropped by the format
	function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	task automatic build_program;
		int         kind;
		int         off;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] last_rd;
		// registers have no reset value, so x1..x7 get written first
		for (int i = 0; i < 7; i++) begin
			mem[i] = enc_i(12'($urandom()), 5'd0, 3'b000, 5'(i + 1));
		end
		last_rd = 5'd7;
		for (int i = 7; i < 64; i++) begin
			kind = $urandom_range(15, 0);
			rd   = 5'($urandom_range(7, 0));
			// half the sources reuse the last rd, forcing hazards
			rs1  = $urandom_range(1, 0) ? last_rd : 5'($urandom_range(7, 0));
			rs2  = $urandom_range(1, 0) ? last_rd : 5'($urandom_range(7, 0));
			off  = $urandom_range(16, 0);
			off  = off - 8;
			case (kind)
				0:         mem[i] = {20'($urandom()), rd, 7'b0110111};
				1, 2, 14:  mem[i] = enc_i(12'($urandom()), rs1, 3'b000, rd);
				3, 12:     mem[i] = enc_r(7'b0000000, rs2, rs1, 3'b000, rd);
				4:         mem[i] = enc_r(7'b0100000, rs2, rs1, 3'b000, rd);
				5:         mem[i] = enc_r(7'b0000000, rs2, rs1, 3'b111, rd);
				6:         mem[i] = enc_r(7'b0000000, rs2, rs1, 3'b110, rd);
				7, 15:     mem[i] = enc_r(7'b0000000, rs2, rs1, 3'b100, rd);
				8:         mem[i] = enc_b(13'(off * 4), rs2, rs1, 3'b000);
				9:         mem[i] = enc_b(13'(off * 4), rs2, rs1, 3'b001);
				10:        mem[i] = enc_j(21'(off * 4), rd);
				// custom-0 opcode, unknown to the core
				11:        mem[i] = {25'($urandom()), 7'b0001011};
				// op-imm with funct3 outside the subset
				default:   mem[i] = enc_i(12'($urandom()), rs1, 3'($urandom_range(7, 1)), rd);
			endcase
			if (!(kind inside {8, 9, 11, 13})) begin
				last_rd = rd;
			end
		end
	endtask

	// ****************************************
	// reference model
	// ****************************************

	task automatic ref_step;
		logic [31:0] inst;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [63:0] a;
		logic [63:0] b;
		logic        use1;
		logic        use2;
		logic [31:0] next_pc;
		inst     = mem[m_pc[7:2]];
		rs1      = inst[19:15];
		rs2      = inst[24:20];
		a        = m_regs[rs1];
		b        = m_regs[rs2];
		use1     = 1'b0;
		use2     = 1'b0;
		e_pc     = m_pc;
		e_writes = 1'b0;
		e_val    = '0;
		e_ctrl   = 1'b0;
		next_pc  = m_pc + 32'd4;
		case (inst[6:0])
			7'b0110111: begin
				e_writes = 1'b1;
				e_val    = {{32{inst[31]}}, inst[31:12], 12'b0};
			end
			7'b0010011: begin
				if (inst[14:12] == 3'b000) begin
					e_writes = 1'b1;
					use1     = 1'b1;
					e_val    = a + {{52{inst[31]}}, inst[31:20]};
				end
			end
			7'b0110011: begin
				e_writes = 1'b1;
				use1     = 1'b1;
				use2     = 1'b1;
				case ({inst[31:25], inst[14:12]})
					10'b0000000_000: e_val = a + b;
					10'b0100000_000: e_val = a - b;
					10'b0000000_111: e_val = a & b;
					10'b0000000_110: e_val = a | b;
					10'b0000000_100: e_val = a ^ b;
					default: begin
						e_writes = 1'b0;
						use1     = 1'b0;
						use2     = 1'b0;
					end
				endcase
			end
			7'b1100011: begin
				if (inst[14:13] == 2'b00) begin
					e_ctrl = 1'b1;
					// beq on funct3 000, bne on 001
					if ((a == b) ^ inst[12]) begin
						next_pc = m_pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
							inst[11:8], 1'b0};
					end
				end
			end
			7'b1101111: begin
				e_writes = 1'b1;
				e_ctrl   = 1'b1;
				e_val    = {32'b0, m_pc + 32'd4};
				next_pc  = m_pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			default: e_writes = 1'b0;
		endcase
		e_rd  = e_writes ? inst[11:7] : 5'd0;
		e_wen = e_writes && (e_rd != 5'd0);
		e_dep = (m_last_rd != 5'd0) && ((use1 && rs1 == m_last_rd) || (use2 && rs2 == m_last_rd));
		if (e_wen) begin
			m_regs[e_rd] = e_val;
			m_last_rd    = e_rd;
		end
		m_pc = next_pc;
	endtask

	// which behavior a mismatch in rd, wen or value belongs to
	function automatic int commit_test();
		if (e_writes && e_rd != 5'd0) begin
			if (e_ctrl) return t_ctrl;
			if (e_dep) return t_hazard;
			return t_alu;
		end
		return e_ctrl ? t_ctrl : t_zero;
	endfunction

	task automatic check_field(input int t, input string name, input logic [63:0] exp,
			input logic [63:0] act);
		checks[t]++;
		if (act !== exp) begin
			errors[t]++;
			$display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic compare_commit;
		int t;
		ref_step();
		check_field(t_ctrl, "commit.pc", e_pc, commit.pc);
		t = commit_test();
		check_field(t, "commit.rd", e_rd, commit.rd);
		check_field(t, "commit.wen", e_wen, commit.wen);
		if (e_writes) begin
			check_field(t, "commit.value", e_val, commit.value);
		end
	endtask

	// ****************************************
	// AXI4-Lite read memory
	// ****************************************

	// runs once per falling edge, handshakes complete on the next rising edge
	task automatic bus_step;
		if (ar_hs) begin
			ar_hs     = 1'b0;
			addr_open = 1'b1;
			arready   = 1'b0;
			r_cnt     = $urandom_range(3, 0);
		end
		if (r_hs) begin
			r_hs      = 1'b0;
			addr_open = 1'b0;
			rvalid    = 1'b0;
			ar_cnt    = $urandom_range(3, 0);
		end
		if (!addr_open) begin
			check_field(t_fetch, "rready", 1'b0, rready);
		end
		// pending address must hold
		if (ar_wait_prev) begin
			check_field(t_fetch, "arvalid", 1'b1, arvalid);
			check_field(t_fetch, "araddr", ar_addr_prev, araddr);
		end
		if (!addr_open) begin
			if (arvalid && ar_cnt == 0) begin
				arready = 1'b1;
				ar_hs   = 1'b1;
				r_addr  = araddr;
			end else if (arvalid) begin
				ar_cnt--;
			end
		end else begin
			if (!rvalid && r_cnt == 0) begin
				rvalid = 1'b1;
				rdata  = mem[r_addr[7:2]];
			end else if (!rvalid) begin
				r_cnt--;
			end
			if (rvalid && rready) begin
				r_hs = 1'b1;
			end
		end
		ar_wait_prev = arvalid && !arready;
		ar_addr_prev = araddr;
	endtask

	// ****************************************
	// main sequence
	// ****************************************

	initial begin
		int n_done;
		int cycles;
		int total_checks;
		int total_errors;
		logic first_seen;
		logic timed_out;
		void'($urandom(32'h051b_93c5));
		rst          = 1'b1;
		arready      = 1'b0;
		rvalid       = 1'b0;
		rdata        = '0;
		ar_hs        = 1'b0;
		r_hs         = 1'b0;
		addr_open    = 1'b0;
		ar_wait_prev = 1'b0;
		ar_addr_prev = '0;
		ar_cnt       = $urandom_range(3, 0);
		r_cnt        = 0;
		n_done       = 0;
		cycles       = 0;
		first_seen   = 1'b0;
		timed_out    = 1'b0;
		for (int i = 0; i < 6; i++) begin
			checks[i] = 0;
			errors[i] = 0;
		end
		for (int i = 0; i < 32; i++) begin
			m_regs[i] = '0;
		end
		m_pc      = `NPC_RESET_PC;
		m_last_rd = 5'd0;
		build_program();
		repeat (2) @(posedge clk);
		@(negedge clk);
		// nothing requests, retires or reads data while in reset
		check_field(t_reset, "arvalid", 1'b0, arvalid);
		check_field(t_reset, "commit_valid", 1'b0, commit_valid);
		check_field(t_reset, "rready", 1'b0, rready);
		rst = 1'b0;
		while (n_done < n_commits && !timed_out) begin
			@(negedge clk);
			cycles++;
			if (cycles > cycle_limit) begin
				timed_out = 1'b1;
				$display("timeout: pipeline stopped committing after %0d of %0d commits",
					n_done, n_commits);
			end else begin
				if (!first_seen && arvalid) begin
					first_seen = 1'b1;
					check_field(t_reset, "araddr", `NPC_RESET_PC, araddr);
					$display("%s: %0d checks, %0d errors", test_name[t_reset],
						checks[t_reset], errors[t_reset]);
				end
				if (commit_valid) begin
					compare_commit();
					n_done++;
				end
				bus_step();
			end
		end
		total_checks = 0;
		total_errors = 0;
		for (int i = 0; i < 6; i++) begin
			if (i != t_reset) begin
				$display("%s: %0d checks, %0d errors", test_name[i], checks[i], errors[i]);
			end
			total_checks += checks[i];
			total_errors += errors[i];
		end
		$display("summary: %0d commits, %0d checks, %0d errors", n_done, total_checks,
			total_errors);
		if (!timed_out && total_errors == 0 && first_seen) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== src/npc_top.sv ====
// core top, joins fetch, decode, register file and execute; fetch bus and commit port outside
`timescale 1ns/1ps
`include "npc_params.svh"

module npc_top import npc_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	output logic                   arvalid,
	output logic [`NPC_ADDR_W-1:0] araddr,
	input  logic                   arready,
	input  logic                   rvalid,
	input  logic [31:0]            rdata,
	output logic                   rready,
	output logic                   commit_valid,
	output npc_commit_t            commit
);

	// ****************************************
	// stage links
	// ****************************************

	// IF -> ID
	logic                 if_valid;
	logic                 if_ready;
	npc_if_id_t           if_data;
	// ID -> EX
	logic                 id_valid;
	logic                 id_ready;
	npc_id_ex_t           id_data;
	// EX -> IF/ID
	npc_redirect_t        redirect;
	// register read and scoreboard
	logic [4:0]           rs1_addr;
	logic [4:0]           rs2_addr;
	logic [`NPC_XLEN-1:0] rs1_data;
	logic [`NPC_XLEN-1:0] rs2_data;
	logic                 rs1_busy;
	logic                 rs2_busy;
	logic                 issue_valid;
	logic [4:0]           issue_rd;

	npc_ifu u_ifu (
		.clk      (clk),
		.rst      (rst),
		.redirect (redirect),
		.arvalid  (arvalid),
		.araddr   (araddr),
		.arready  (arready),
		.rvalid   (rvalid),
		.rdata    (rdata),
		.rready   (rready),
		.if_valid (if_valid),
		.if_ready (if_ready),
		.if_data  (if_data)
	);

	npc_idu u_idu (
		.clk         (clk),
		.rst         (rst),
		.if_valid    (if_valid),
		.if_ready    (if_ready),
		.if_data     (if_data),
		.redirect    (redirect),
		.rs1_addr    (rs1_addr),
		.rs2_addr    (rs2_addr),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.rs1_busy    (rs1_busy),
		.rs2_busy    (rs2_busy),
		.issue_valid (issue_valid),
		.issue_rd    (issue_rd),
		.id_valid    (id_valid),
		.id_ready    (id_ready),
		.id_data     (id_data)
	);

	// writes come straight from the commit port
	npc_gpr u_gpr (
		.clk          (clk),
		.rst          (rst),
		.rs1_addr     (rs1_addr),
		.rs2_addr     (rs2_addr),
		.rs1_data     (rs1_data),
		.rs2_data     (rs2_data),
		.rs1_busy     (rs1_busy),
		.rs2_busy     (rs2_busy),
		.issue_valid  (issue_valid),
		.issue_rd     (issue_rd),
		.commit_valid (commit_valid),
		.commit       (commit)
	);

	npc_exu u_exu (
		.clk          (clk),
		.rst          (rst),
		.id_valid     (id_valid),
		.id_ready     (id_ready),
		.id_data      (id_data),
		.redirect     (redirect),
		.commit_valid (commit_valid),
		.commit       (commit)
	);

endmodule

// ==== src/npc_exu.sv ====
// execute stage, ALU and branch resolution, registers the commit record that writes back
`timescale 1ns/1ps
`include "npc_params.svh"

module npc_exu import npc_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  logic          id_valid,
	output logic          id_ready,
	input  npc_id_ex_t    id_data,
	output npc_redirect_t redirect,
	output logic          commit_valid,
	output npc_commit_t   commit
);

	logic [`NPC_XLEN-1:0]   a;
	logic [`NPC_XLEN-1:0]   b;
	logic [`NPC_XLEN-1:0]   imm;
	logic [`NPC_XLEN-1:0]   result;
	logic [`NPC_ADDR_W-1:0] pc_plus4;
	logic [`NPC_ADDR_W-1:0] target;
	logic                   taken;
	logic                   writes;
	logic                   commit_valid_q;
	npc_commit_t            commit_q;

	assign a   = id_data.src_a;
	assign b   = id_data.src_b;
	assign imm = id_data.imm;

	// commit never back-pressures
	assign id_ready = 1'b1;

	// ****************************************
	// ALU and branch
	// ****************************************

	assign pc_plus4 = id_data.pc + 32'd4;
	// pc-relative, upper imm bits fall off the address width
	assign target   = id_data.pc + imm[`NPC_ADDR_W-1:0];

	always_comb begin
		result = '0;
		taken  = 1'b0;
		writes = 1'b1;
		case (id_data.op)
			op_lui:  result = imm;
			op_addi: result = a + imm;
			op_add:  result = a + b;
			op_sub:  result = a - b;
			op_and:  result = a & b;
			op_or:   result = a | b;
			op_xor:  result = a ^ b;
			op_jal: begin
				// link value, pc zero-extended
				result = `NPC_XLEN'(pc_plus4);
				taken  = 1'b1;
			end
			op_beq: begin
				taken  = (a == b);
				writes = 1'b0;
			end
			op_bne: begin
				taken  = (a != b);
				writes = 1'b0;
			end
			default: writes = 1'b0;
		endcase
	end

	// valid in the acceptance cycle only
	assign redirect.taken  = id_valid && taken;
	assign redirect.target = target;

	// ****************************************
	// commit register
	// ****************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			commit_valid_q <= 1'b0;
		end else begin
			commit_valid_q <= id_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (id_valid) begin
			commit_q.pc    <= id_data.pc;
			commit_q.rd    <= id_data.rd;
			commit_q.wen   <= writes && (id_data.rd != 5'd0);
			commit_q.value <= result;
		end
	end

	assign commit_valid = commit_valid_q;
	assign commit       = commit_q;

endmodule

// ==== src/npc_idu.sv ====
// decode stage, reads operands, stalls on busy sources, holds the ID/EX register
`timescale 1ns/1ps
`include "npc_params.svh"

module npc_idu import npc_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 if_valid,
	output logic                 if_ready,
	input  npc_if_id_t           if_data,
	input  npc_redirect_t        redirect,
	output logic [4:0]           rs1_addr,
	output logic [4:0]           rs2_addr,
	input  logic [`NPC_XLEN-1:0] rs1_data,
	input  logic [`NPC_XLEN-1:0] rs2_data,
	input  logic                 rs1_busy,
	input  logic                 rs2_busy,
	output logic                 issue_valid,
	output logic [4:0]           issue_rd,
	output logic                 id_valid,
	input  logic                 id_ready,
	output npc_id_ex_t           id_data
);

	logic [31:0]          inst;
	logic [6:0]           opcode;
	logic [2:0]           funct3;
	logic [6:0]           funct7;
	npc_op_e              op;
	logic                 use_rs1;
	logic                 use_rs2;
	logic                 wr_rd;
	logic                 stall;
	logic [`NPC_XLEN-1:0] imm_i;
	logic [`NPC_XLEN-1:0] imm_u;
	logic [`NPC_XLEN-1:0] imm_b;
	logic [`NPC_XLEN-1:0] imm_j;
	npc_id_ex_t           dec;
	logic                 id_valid_q;
	npc_id_ex_t           id_data_q;

	assign inst   = if_data.inst;
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	// ****************************************
	// decode
	// ****************************************

	always_comb begin
		op = op_nop;
		case (opcode)
			7'b0110111: op = op_lui;
			7'b1101111: op = op_jal;
			7'b0010011: begin
				if (funct3 == 3'b000) begin
					op = op_addi;
				end
			end
			7'b0110011: begin
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: op = op_add;
					{7'b0100000, 3'b000}: op = op_sub;
					{7'b0000000, 3'b111}: op = op_and;
					{7'b0000000, 3'b110}: op = op_or;
					{7'b0000000, 3'b100}: op = op_xor;
					default:              op = op_nop;
				endcase
			end
			7'b1100011: begin
				if (funct3 == 3'b000) begin
					op = op_beq;
				end else if (funct3 == 3'b001) begin
					op = op_bne;
				end
			end
			default: op = op_nop;
		endcase
	end

	// which operands and destination the op really touches
	assign use_rs1 = op inside {op_addi, op_add, op_sub, op_and, op_or, op_xor, op_beq, op_bne};
	assign use_rs2 = op inside {op_add, op_sub, op_and, op_or, op_xor, op_beq, op_bne};
	assign wr_rd   = op inside {op_lui, op_addi, op_add, op_sub, op_and, op_or, op_xor, op_jal};

	// immediates, all sign-extended to XLEN
	assign imm_i = {{(`NPC_XLEN-12){inst[31]}}, inst[31:20]};
	assign imm_u = {{(`NPC_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
	assign imm_b = {{(`NPC_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_j = {{(`NPC_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	assign rs1_addr = inst[19:15];
	assign rs2_addr = inst[24:20];

	always_comb begin
		dec.pc    = if_data.pc;
		dec.op    = op;
		// rd forced to zero for branches and unknowns
		dec.rd    = wr_rd ? inst[11:7] : 5'd0;
		dec.src_a = rs1_data;
		dec.src_b = rs2_data;
		case (op)
			op_lui:         dec.imm = imm_u;
			op_addi:        dec.imm = imm_i;
			op_beq, op_bne: dec.imm = imm_b;
			op_jal:         dec.imm = imm_j;
			default:        dec.imm = '0;
		endcase
	end

	// ****************************************
	// hazard and issue
	// ****************************************

	assign stall = (use_rs1 && rs1_busy) || (use_rs2 && rs2_busy);

	// nothing after a taken branch may enter, it is wrong path
	assign if_ready    = !redirect.taken && !stall && (!id_valid_q || id_ready);
	assign issue_valid = if_valid && if_ready;
	assign issue_rd    = dec.rd;

	always_ff @(posedge clk) begin
		if (rst) begin
			id_valid_q <= 1'b0;
		end else if (issue_valid) begin
			id_valid_q <= 1'b1;
		end else if (id_ready || redirect.taken) begin
			id_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_valid) begin
			id_data_q <= dec;
		end
	end

	assign id_valid = id_valid_q;
	assign id_data  = id_data_q;

endmodule

// ==== src/npc_gpr.sv ====
// general register file with x0 tied to zero and the scoreboard that tracks pending writes
`timescale 1ns/1ps
`include "npc_params.svh"

module npc_gpr import npc_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [4:0]           rs1_addr,
	input  logic [4:0]           rs2_addr,
	output logic [`NPC_XLEN-1:0] rs1_data,
	output logic [`NPC_XLEN-1:0] rs2_data,
	output logic                 rs1_busy,
	output logic                 rs2_busy,
	input  logic                 issue_valid,
	input  logic [4:0]           issue_rd,
	input  logic                 commit_valid,
	input  npc_commit_t          commit
);

	logic [`NPC_XLEN-1:0] regs [1:31];
	// writers in flight per register, at most two (ID/EX and commit)
	// a plain bit would clear early when two writes to one rd overlap
	logic [1:0]           busy_cnt [1:31];
	logic [31:1]          inc_vec;
	logic [31:1]          dec_vec;

	// ****************************************
	// read ports
	// ****************************************

	assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];
	assign rs1_busy = (rs1_addr != 5'd0) && (busy_cnt[rs1_addr] != 2'd0);
	assign rs2_busy = (rs2_addr != 5'd0) && (busy_cnt[rs2_addr] != 2'd0);

	// ****************************************
	// scoreboard
	// ****************************************

	// issue and commit on one rd cancel out, register stays busy
	always_comb begin
		for (int i = 1; i < 32; i++) begin
			inc_vec[i] = issue_valid && (issue_rd == 5'(i));
			dec_vec[i] = commit_valid && (commit.rd == 5'(i));
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				busy_cnt[i] <= 2'd0;
			end
		end else begin
			for (int i = 1; i < 32; i++) begin
				case ({inc_vec[i], dec_vec[i]})
					2'b10:   busy_cnt[i] <= busy_cnt[i] + 2'd1;
					2'b01:   busy_cnt[i] <= busy_cnt[i] - 2'd1;
					default: busy_cnt[i] <= busy_cnt[i];
				endcase
			end
		end
	end

	// writeback on the commit edge
	always_ff @(posedge clk) begin
		if (commit_valid && commit.wen && (commit.rd != 5'd0)) begin
			regs[commit.rd] <= commit.value;
		end
	end

endmodule

// ==== src/npc_ifu.sv ====
// instruction fetch unit, one AXI4-Lite read per instruction, feeds decode over valid/ready
`timescale 1ns/1ps
`include "npc_params.svh"

module npc_ifu import npc_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  npc_redirect_t          redirect,
	output logic                   arvalid,
	output logic [`NPC_ADDR_W-1:0] araddr,
	input  logic                   arready,
	input  logic                   rvalid,
	input  logic [31:0]            rdata,
	output logic                   rready,
	output logic                   if_valid,
	input  logic                   if_ready,
	output npc_if_id_t             if_data
);

	npc_fetch_state_e       state;
	// address of the word in flight, also its pc toward decode
	logic [`NPC_ADDR_W-1:0] pc_q;
	// redirect target parked while a stale read finishes
	logic [`NPC_ADDR_W-1:0] tgt_q;
	// address phase already known to be wrong path
	logic                   stale_q;
	logic                   if_valid_q;
	logic [31:0]            inst_q;
	// first request goes out once reset is over
	logic                   run_q;

	// ****************************************
	// bus and stage outputs
	// ****************************************

	// no new request while a word waits for decode
	assign arvalid  = run_q && (state == fs_addr) && !if_valid_q;
	assign araddr   = pc_q;
	assign rready   = (state == fs_data) || (state == fs_drop);
	assign if_valid = if_valid_q;
	assign if_data  = '{pc: pc_q, inst: inst_q};

	// ****************************************
	// fetch FSM
	// ****************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= fs_addr;
			pc_q       <= `NPC_RESET_PC;
			stale_q    <= 1'b0;
			if_valid_q <= 1'b0;
			run_q      <= 1'b0;
		end else begin
			run_q <= 1'b1;
			case (state)
				fs_addr: begin
					if (if_valid_q) begin
						// holding a word, redirect wins over handoff
						if (redirect.taken) begin
							if_valid_q <= 1'b0;
							pc_q       <= redirect.target;
						end else if (if_ready) begin
							if_valid_q <= 1'b0;
							pc_q       <= pc_q + 32'd4;
						end
					end else begin
						// araddr must stay put until arready
						if (redirect.taken) begin
							stale_q <= 1'b1;
							tgt_q   <= redirect.target;
						end
						if (arvalid && arready) begin
							if (stale_q || redirect.taken) begin
								state <= fs_drop;
							end else begin
								state <= fs_data;
							end
						end
					end
				end
				fs_data: begin
					if (redirect.taken) begin
						if (rvalid) begin
							// beat ends now, just throw it away
							pc_q  <= redirect.target;
							state <= fs_addr;
						end else begin
							tgt_q <= redirect.target;
							state <= fs_drop;
						end
					end else if (rvalid) begin
						inst_q     <= rdata;
						if_valid_q <= 1'b1;
						state      <= fs_addr;
					end
				end
				fs_drop: begin
					if (redirect.taken) begin
						tgt_q <= redirect.target;
					end
					// swallow the wrong-path beat, restart at target
					if (rvalid) begin
						pc_q    <= redirect.taken ? redirect.target : tgt_q;
						stale_q <= 1'b0;
						state   <= fs_addr;
					end
				end
				default: state <= fs_addr;
			endcase
		end
	end

endmodule

// ==== src/npc_pkg.sv ====
// shared types of the core: decoded operations, fetch states and stage records
`include "npc_params.svh"

package npc_pkg;

	// ****************************************
	// enums
	// ****************************************

	// decoded operation, anything unsupported lands on op_nop
	typedef enum logic [3:0] {
		op_lui,
		op_addi,
		op_add,
		op_sub,
		op_and,
		op_or,
		op_xor,
		op_beq,
		op_bne,
		op_jal,
		op_nop
	} npc_op_e;

	// fetch FSM
	// fs_addr  address phase, or holding a fetched word
	// fs_data  waiting for the R beat
	// fs_drop  R beat belongs to the wrong path
	typedef enum logic [1:0] {
		fs_addr,
		fs_data,
		fs_drop
	} npc_fetch_state_e;

	// ****************************************
	// stage records
	// ****************************************

	// IF -> ID
	typedef struct packed {
		logic [`NPC_ADDR_W-1:0] pc;
		logic [31:0]            inst;
	} npc_if_id_t;

	// ID -> EX, operands already read
	typedef struct packed {
		logic [`NPC_ADDR_W-1:0] pc;
		npc_op_e                op;
		logic [4:0]             rd;
		logic [`NPC_XLEN-1:0]   src_a;
		logic [`NPC_XLEN-1:0]   src_b;
		logic [`NPC_XLEN-1:0]   imm;
	} npc_id_ex_t;

	// retired instruction, also the register file write
	typedef struct packed {
		logic [`NPC_ADDR_W-1:0] pc;
		logic [4:0]             rd;
		logic                   wen;
		logic [`NPC_XLEN-1:0]   value;
	} npc_commit_t;

	// EX -> IF/ID control flow change
	typedef struct packed {
		logic                   taken;
		logic [`NPC_ADDR_W-1:0] target;
	} npc_redirect_t;

endpackage

// ==== include/npc_params.svh ====
// core-wide widths and reset PC, included by the RTL, the package and the testbench
`ifndef NPC_PARAMS_SVH
`define NPC_PARAMS_SVH

// ****************************************
// datapath
// ****************************************

// integer register and ALU width, RV64
`define NPC_XLEN 64

// ****************************************
// fetch side
// ****************************************

// byte address width on the AXI4-Lite read channel
`define NPC_ADDR_W 32

// first instruction fetched after reset
`define NPC_RESET_PC 32'h0000_0000

`endif
